// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o; // 8 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: bench/cpu_patterns.txt
# kind address word: I program word, D initial data word, W expected store in order
# byte addresses and words in hex, anything after a hash is ignored
I 00000000 00500093 # addi x1, x0, 5
I 00000004 ffd00113 # addi x2, x0, -3
I 00000008 002081b3 # add  x3, x1, x2
I 0000000c 20302023 # sw   x3, 0x200(x0)
I 00000010 40110233 # sub  x4, x2, x1
I 00000014 002222b3 # slt  x5, x4, x2
I 00000018 0040a333 # slt  x6, x1, x4
I 0000001c 0042e3b3 # or   x7, x5, x4
I 00000020 20702223 # sw   x7, 0x204(x0)
I 00000024 0062c433 # xor  x8, x5, x6
I 00000028 abcde4b7 # lui  x9, 0xabcde
I 0000002c 1234e493 # ori  x9, x9, 0x123
I 00000030 0ff4f513 # andi x10, x9, 0xff
I 00000034 008505b3 # add  x11, x10, x8
I 00000038 20902423 # sw   x9, 0x208(x0)
I 0000003c 20b02623 # sw   x11, 0x20c(x0)
I 00000040 10002603 # lw   x12, 0x100(x0)
I 00000044 001606b3 # add  x13, x12, x1
I 00000048 10402703 # lw   x14, 0x104(x0)
I 0000004c 20e02823 # sw   x14, 0x210(x0)
I 00000050 20d02a23 # sw   x13, 0x214(x0)
I 00000054 00308463 # beq  x1, x3, +8 not taken
I 00000058 00309463 # bne  x1, x3, +8 taken
I 0000005c 30002023 # sw   x0, 0x300(x0) skipped
I 00000060 00100813 # addi x16, x0, 1
I 00000064 00580463 # beq  x16, x5, +8 taken
I 00000068 30102223 # sw   x1, 0x304(x0) skipped
I 0000006c 00319463 # bne  x3, x3, +8 not taken
I 00000070 00c007ef # jal  x15, +12
I 00000074 30202423 # sw   x2, 0x308(x0) skipped
I 00000078 30202623 # sw   x2, 0x30c(x0) skipped
I 0000007c 20f02c23 # sw   x15, 0x218(x0)
I 00000080 0000006f # jal  x0, 0
D 00000100 12345678
D 00000104 fffffff0
W 00000200 00000002 # 5 + -3
W 00000204 fffffff9 # slt 1 or -8
W 00000208 abcde123 # lui then ori
W 0000020c 00000024 # 0x23 + 1
W 00000210 fffffff0 # loaded word
W 00000214 1234567d # loaded word + 5
W 00000218 00000074 # jal link

// File: bench/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
  import rv_pkg::*;

  typedef enum logic [1:0] {M_IDLE, M_WAIT, M_ACK} mem_state_e;

  logic        clk;
  logic        rst_n;
  logic        start = 1'b0;
  xlen_t       imem_addr;
  instr_t      imem_data;
  logic        mem_req;
  dmem_req_t   mem_bus;
  logic        mem_ack = 1'b0;
  xlen_t       mem_rdata = '0;

  instr_t      rom [256];
  xlen_t       dmem [256];
  xlen_t       init_addr_q [$];
  xlen_t       init_data_q [$];
  xlen_t       exp_addr_q [$];
  xlen_t       exp_data_q [$];
  mem_state_e  mstate;
  dmem_req_t   held_bus;
  logic [1:0]  wait_cnt;
  logic [31:0] rnd;
  logic        req_prev;
  logic        all_stores_seen;
  int          seed = 32'hf950_ea7a;
  int          cycles;
  int          cycle_limit;
  int          n_stores;

  clk_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  cpu_top dut0 (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .start_i     (start),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .mem_req_o   (mem_req),
    .mem_bus_o   (mem_bus),
    .mem_ack_i   (mem_ack),
    .mem_rdata_i (mem_rdata)
  );

  assign imem_data = rom[imem_addr[9:2]]; // combinational instruction port

  task automatic fail_run;
    $display("STATUS: FAIL");
    $fatal(1, "testbench stopped at the first error");
  endtask

  // stores must arrive in program order
  task automatic check_store(input dmem_req_t bus);
    if (exp_addr_q.size() == 0) begin
      $display("store to %h with data %h after the last expected store", bus.addr, bus.wdata);
      fail_run();
    end else begin
      assert (bus.addr == exp_addr_q[0]) else begin
        $display("MISMATCH at %0t: mem_bus_o.addr got %h expected %h",
                 $time, bus.addr, exp_addr_q[0]);
        fail_run();
      end
      assert (bus.wdata == exp_data_q[0]) else begin
        $display("MISMATCH at %0t: mem_bus_o.wdata got %h expected %h",
                 $time, bus.wdata, exp_data_q[0]);
        fail_run();
      end
      void'(exp_addr_q.pop_front());
      void'(exp_data_q.pop_front());
      n_stores++;
      if (exp_addr_q.size() == 0) all_stores_seen <= 1'b1;
    end
  endtask

  initial begin : load_patterns
    int               fd;
    int               rc;
    int               n_lines;
    logic [8*128-1:0] line;
    logic [7:0]       tag;
    xlen_t            addr;
    xlen_t            data;
    n_lines = 0;
    cycle_limit = 100;
    for (int i = 0; i < 256; i++) begin
      rom[i] = {i[11:0], 5'd0, 3'b000, 5'd0, OP_I}; // addi x0, x0, index
    end
    fd = $fopen("bench/cpu_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/cpu_patterns.txt");
      fail_run();
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        tag = '0;
        rc = $fgets(line, fd);
        rc = $sscanf(line, "%s %h %h", tag, addr, data);
        if (rc == 3 && tag != "#") begin
          n_lines++;
          case (tag)
            "I": rom[addr[9:2]] = data;
            "D": begin
              init_addr_q.push_back(addr);
              init_data_q.push_back(data);
            end
            "W": begin
              exp_addr_q.push_back(addr);
              exp_data_q.push_back(data);
            end
            default: begin
              $display("unknown line kind %s in the pattern file", tag);
              fail_run();
            end
          endcase
        end
      end
      $fclose(fd);
      cycle_limit = 100 + 12 * n_lines;
      if (exp_addr_q.size() == 0) begin
        $display("pattern file holds no expected stores");
        fail_run();
      end
    end
  end

  initial begin : start_core
    @(posedge rst_n);
    repeat (2) @(posedge clk);
    start <= 1'b1;
  end

  // four-phase slave with a random ack delay
  always @(posedge clk) begin : data_memory
    if (!rst_n) begin
      mstate <= M_IDLE;
      mem_ack <= 1'b0;
      all_stores_seen <= 1'b0;
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= 32'hbad0_0000 ^ (32'(i) << 2);
      end
      foreach (init_addr_q[k]) begin
        dmem[init_addr_q[k][9:2]] <= init_data_q[k];
      end
    end else begin
      case (mstate)
        M_IDLE: begin
          if (mem_req) begin
            rnd = $random(seed);
            wait_cnt <= rnd[1:0]; // ack 1 to 4 cycles later
            held_bus <= mem_bus;
            mstate <= M_WAIT;
            if (mem_bus.we) check_store(mem_bus);
          end
        end
        M_WAIT: begin
          if (wait_cnt == 2'd0) begin
            mem_ack <= 1'b1;
            mem_rdata <= dmem[held_bus.addr[9:2]];
            if (held_bus.we) dmem[held_bus.addr[9:2]] <= held_bus.wdata;
            mstate <= M_ACK;
          end else begin
            wait_cnt <= wait_cnt - 2'd1;
          end
        end
        default: begin
          if (!mem_req) begin
            mem_ack <= 1'b0;
            mstate <= M_IDLE;
          end
        end
      endcase
    end
  end

  always @(posedge clk) begin : protocol_monitor
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d stores never seen", cycles, exp_addr_q.size());
      fail_run();
    end
    if (rst_n && !start) begin
      assert (!mem_req) else begin
        $display("mem_req_o rose before start_i");
        fail_run();
      end
      assert (imem_addr == 32'h0) else begin
        $display("MISMATCH at %0t: imem_addr_o got %h expected %h", $time, imem_addr, 32'h0);
        fail_run();
      end
    end
    if (rst_n) begin
      assert (!(mem_req && !req_prev && mem_ack)) else begin
        $display("new request raised at %0t while ack was still high", $time);
        fail_run();
      end
      assert (!(req_prev && !mem_req && !mem_ack)) else begin
        $display("request dropped at %0t before ack was seen", $time);
        fail_run();
      end
      if (req_prev && mem_req) begin
        assert (mem_bus == held_bus) else begin
          $display("MISMATCH at %0t: mem_bus_o got %h expected %h", $time, mem_bus, held_bus);
          fail_run();
        end
      end
    end
    req_prev = mem_req;
  end

  initial begin : finish_run
    wait (all_stores_seen === 1'b1);
    @(posedge clk);
    while (mem_req || mem_ack) begin
      @(posedge clk); // last handshake still closing
    end
    $display("all %0d stores matched", n_stores);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the core and its testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_cpu -f sim.f -o tb_cpu \
  && ./obj_dir/tb_cpu > sim.log 2>&1 \
  || echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -qx "STATUS: PASS" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// File: sim.f
src/rv_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/reg_file.sv
src/alu.sv
src/hazard_unit.sv
src/mem_port.sv
src/cpu_top.sv
bench/clk_gen.sv
bench/tb_cpu.sv

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
  input  rv_pkg::alu_op_e op_i,
  input  rv_pkg::xlen_t   a_i,
  input  rv_pkg::xlen_t   b_i,
  output rv_pkg::xlen_t   y_o
);
  import rv_pkg::*;

  logic lt_signed;

  assign lt_signed = $signed(a_i) < $signed(b_i);

  always_comb begin
    case (op_i)
      SUB:     y_o = a_i - b_i;
      AND:     y_o = a_i & b_i;
      OR:      y_o = a_i | b_i;
      XOR:     y_o = a_i ^ b_i;
      SLT:     y_o = {31'b0, lt_signed};
      PASS_B:  y_o = b_i;        // lui
      default: y_o = a_i + b_i;  // add, address calc
    endcase
  end

endmodule

// File: src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              start_i,
  output rv_pkg::xlen_t     imem_addr_o,
  input  rv_pkg::instr_t    imem_data_i,
  output logic              mem_req_o,
  output rv_pkg::dmem_req_t mem_bus_o,
  input  logic              mem_ack_i,
  input  rv_pkg::xlen_t     mem_rdata_i
);
  import rv_pkg::*;

  typedef struct packed {
    xlen_t  pc;
    instr_t instr;
  } if_id_t;

  if_id_t    if_id;
  id_ex_t    id_ex;
  id_ex_t    id_ex_d;
  ex_mem_t   ex_mem;
  ex_mem_t   ex_mem_d;
  mem_wb_t   mem_wb;
  mem_wb_t   mem_wb_d;
  ctrl_t     ctrl;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  fwd_sel_e  fwd1;
  fwd_sel_e  fwd2;
  xlen_t     pc;
  xlen_t     imm;
  xlen_t     rdata1;
  xlen_t     rdata2;
  xlen_t     src1;
  xlen_t     src2;
  xlen_t     alu_y;
  xlen_t     ex_fwd;
  xlen_t     wb_data;
  xlen_t     load_data;
  logic      taken;
  logic      flush;
  logic      load_stall;
  logic      mem_stall;

  fetch_unit u_fetch (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (start_i),
    .stall_i    (load_stall || mem_stall),
    .redirect_i (flush),
    .target_i   (if_id.pc + imm),
    .pc_o       (pc)
  );
  assign imem_addr_o = pc;

  decoder u_dec (
    .instr_i (if_id.instr),
    .ctrl_o  (ctrl),
    .imm_o   (imm),
    .rs1_o   (rs1),
    .rs2_o   (rs2),
    .rd_o    (rd)
  );

  reg_file u_rf (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .wb_i     (mem_wb),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  hazard_unit u_hazard (
    .rs1_i           (rs1),
    .rs2_i           (rs2),
    .ex_rd_i         (id_ex.rd),
    .ex_mem_read_i   (id_ex.ctrl.mem_read),
    .ex_reg_write_i  (id_ex.ctrl.reg_write),
    .mem_rd_i        (ex_mem.rd),
    .mem_reg_write_i (ex_mem.rd != '0),
    .branch_taken_i  (taken),
    .fwd1_o          (fwd1),
    .fwd2_o          (fwd2),
    .load_stall_o    (load_stall),
    .flush_o         (flush)
  );

  function automatic xlen_t fwd_mux(fwd_sel_e sel, xlen_t rf, xlen_t ex, xlen_t mem);
    case (sel)
      FWD_EX:  return ex;
      FWD_MEM: return mem;
      default: return rf;
    endcase
  endfunction

  assign src1  = fwd_mux(fwd1, rdata1, ex_fwd, wb_data);
  assign src2  = fwd_mux(fwd2, rdata2, ex_fwd, wb_data);
  assign taken = ctrl.is_jal || (ctrl.is_branch && ((src1 == src2) ^ ctrl.branch_ne));

  always_comb begin
    id_ex_d.pc4        = if_id.pc + 32'd4;
    id_ex_d.op_a       = ctrl.use_pc_a ? '0 : src1;
    id_ex_d.op_b       = ctrl.use_imm ? imm : src2;
    id_ex_d.store_data = src2;
    id_ex_d.rd         = ctrl.reg_write ? rd : '0; // rd 0 marks no write downstream
    id_ex_d.ctrl       = ctrl;
  end

  alu u_alu (
    .op_i (id_ex.ctrl.alu_op),
    .a_i  (id_ex.op_a),
    .b_i  (id_ex.op_b),
    .y_o  (alu_y)
  );

  // jal link value must be forwarded, not the alu output
  assign ex_fwd = (id_ex.ctrl.wb_src == WB_PC4) ? id_ex.pc4 : alu_y;

  always_comb begin
    ex_mem_d.pc4        = id_ex.pc4;
    ex_mem_d.alu_result = alu_y;
    ex_mem_d.store_data = id_ex.store_data;
    ex_mem_d.rd         = id_ex.rd;
    ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
    ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
    ex_mem_d.wb_src     = id_ex.ctrl.wb_src;
  end

  mem_port u_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .access_i    (ex_mem.mem_read || ex_mem.mem_write),
    .req_i       ('{we: ex_mem.mem_write, addr: ex_mem.alu_result, wdata: ex_mem.store_data}),
    .mem_req_o   (mem_req_o),
    .mem_bus_o   (mem_bus_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .rdata_o     (load_data),
    .stall_o     (mem_stall)
  );

  always_comb begin
    case (ex_mem.wb_src)
      WB_MEM:  wb_data = load_data;
      WB_PC4:  wb_data = ex_mem.pc4;
      default: wb_data = ex_mem.alu_result;
    endcase
  end

  assign mem_wb_d = '{rd: ex_mem.rd, wb_data: wb_data, reg_write: ex_mem.rd != '0};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id  <= '{pc: RESET_PC, instr: NOP_INSTR};
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end else if (!mem_stall) begin
      if (!load_stall) begin
        if_id.pc    <= pc;
        if_id.instr <= (flush || !start_i) ? NOP_INSTR : imem_data_i;
      end
      id_ex  <= load_stall ? '0 : id_ex_d; // bubble on load-use
      ex_mem <= ex_mem_d;
      mem_wb <= mem_wb_d;
    end
  end

endmodule

// File: src/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  rv_pkg::instr_t    instr_i,
  output rv_pkg::ctrl_t     ctrl_o,
  output rv_pkg::xlen_t     imm_o,
  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  output rv_pkg::reg_addr_t rd_o
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i_type;
  xlen_t      imm_s_type;
  xlen_t      imm_b_type;
  xlen_t      imm_u_type;
  xlen_t      imm_j_type;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];
  assign rd_o   = instr_i[11:7];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb begin
    ctrl_o = '0; // nop unless matched below
    imm_o  = imm_i_type;
    case (opcode)
      OP_R: begin
        ctrl_o.reg_write = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = (funct7 == 7'b0100000) ? SUB : ADD;
          3'b010:  ctrl_o.alu_op = SLT;
          3'b100:  ctrl_o.alu_op = XOR;
          3'b110:  ctrl_o.alu_op = OR;
          3'b111:  ctrl_o.alu_op = AND;
          default: ctrl_o.reg_write = 1'b0;
        endcase
      end
      OP_I: begin
        ctrl_o.use_imm   = 1'b1;
        ctrl_o.reg_write = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ADD;
          3'b110:  ctrl_o.alu_op = OR;
          3'b111:  ctrl_o.alu_op = AND;
          default: ctrl_o.reg_write = 1'b0;
        endcase
      end
      OP_LUI: begin
        ctrl_o.alu_op    = PASS_B;
        ctrl_o.use_imm   = 1'b1;
        ctrl_o.use_pc_a  = 1'b1;
        ctrl_o.reg_write = 1'b1;
        imm_o            = imm_u_type;
      end
      OP_LOAD: begin
        ctrl_o.use_imm   = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.mem_read  = 1'b1;
        ctrl_o.wb_src    = WB_MEM;
      end
      OP_STORE: begin
        ctrl_o.use_imm   = 1'b1;
        ctrl_o.mem_write = 1'b1;
        imm_o            = imm_s_type;
      end
      OP_BRANCH: begin
        ctrl_o.is_branch = (funct3[2:1] == 2'b00); // beq / bne only
        ctrl_o.branch_ne = funct3[0];
        imm_o            = imm_b_type;
      end
      OP_JAL: begin
        ctrl_o.is_jal    = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.wb_src    = WB_PC4;
        imm_o            = imm_j_type;
      end
      default: ;
    endcase
  end

  always_comb begin
    assert (!(ctrl_o.mem_read && ctrl_o.mem_write))
      else $error("decoder: load and store decoded together");
  end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          start_i,
  input  logic          stall_i,
  input  logic          redirect_i,
  input  rv_pkg::xlen_t target_i,
  output rv_pkg::xlen_t pc_o
);
  import rv_pkg::*;

  xlen_t pc_q;
  xlen_t pc_next;

  // taken branch or jal from decode replaces the sequential pc
  assign pc_next = redirect_i ? target_i : pc_q + 32'd4;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else if (start_i && !stall_i) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

endmodule

// File: src/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  rv_pkg::reg_addr_t rs1_i,
  input  rv_pkg::reg_addr_t rs2_i,
  input  rv_pkg::reg_addr_t ex_rd_i,
  input  logic              ex_mem_read_i,
  input  logic              ex_reg_write_i,
  input  rv_pkg::reg_addr_t mem_rd_i,
  input  logic              mem_reg_write_i,
  input  logic              branch_taken_i,
  output rv_pkg::fwd_sel_e  fwd1_o,
  output rv_pkg::fwd_sel_e  fwd2_o,
  output logic              load_stall_o,
  output logic              flush_o
);
  import rv_pkg::*;

  logic ex_live;
  logic mem_live;

  assign ex_live  = ex_reg_write_i && ex_rd_i != '0;
  assign mem_live = mem_reg_write_i && mem_rd_i != '0;

  // youngest producer wins
  function automatic fwd_sel_e pick(reg_addr_t rs);
    if (ex_live && ex_rd_i == rs) begin
      return FWD_EX;
    end else if (mem_live && mem_rd_i == rs) begin
      return FWD_MEM;
    end
    return FWD_RF;
  endfunction

  always_comb begin
    fwd1_o = pick(rs1_i);
    fwd2_o = pick(rs2_i);
  end

  // load result not ready until it leaves memory
  assign load_stall_o = ex_mem_read_i && ex_live && (ex_rd_i == rs1_i || ex_rd_i == rs2_i);
  assign flush_o      = branch_taken_i && !load_stall_o;

  always_comb begin
    assert (!(load_stall_o && flush_o)) else $error("hazard: stall and flush together");
  end

endmodule

// File: src/mem_port.sv
`timescale 1ns/1ps

module mem_port (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              access_i,
  input  rv_pkg::dmem_req_t req_i,
  output logic              mem_req_o,
  output rv_pkg::dmem_req_t mem_bus_o,
  input  logic              mem_ack_i,
  input  rv_pkg::xlen_t     mem_rdata_i,
  output rv_pkg::xlen_t     rdata_o,
  output logic              stall_o
);
  import rv_pkg::*;

  typedef enum logic [1:0] {IDLE, REQ, RELEASE, DONE} state_e;

  state_e state_q;
  state_e state_d;
  xlen_t  rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (access_i) state_d = REQ;
      REQ:     if (mem_ack_i) state_d = RELEASE;
      RELEASE: if (!mem_ack_i) state_d = DONE;
      default: state_d = IDLE; // done, pipeline moves on
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == REQ && mem_ack_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign mem_req_o = (state_q == REQ);
  assign mem_bus_o = req_i;  // held by the frozen EX/MEM register
  assign rdata_o   = rdata_q;
  assign stall_o   = (state_q == IDLE) ? access_i : (state_q != DONE);

  a_req_until_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o && !mem_ack_i |=> mem_req_o);

  a_bus_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o |=> !mem_req_o || $stable(mem_bus_o));

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  rv_pkg::reg_addr_t rs1_i,
  input  rv_pkg::reg_addr_t rs2_i,
  input  rv_pkg::mem_wb_t   wb_i,
  output rv_pkg::xlen_t     rdata1_o,
  output rv_pkg::xlen_t     rdata2_o
);
  import rv_pkg::*;

  xlen_t regs [32];

  // x0 reads zero, a same-cycle write is returned directly
  function automatic xlen_t read_port(reg_addr_t rs);
    if (rs == '0) begin
      return '0;
    end else if (wb_i.reg_write && wb_i.rd == rs) begin
      return wb_i.wb_data;
    end
    return regs[rs];
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.reg_write && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.wb_data;
    end
  end

  always_comb begin
    rdata1_o = read_port(rs1_i);
    rdata2_o = read_port(rs2_i);
  end

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] instr_t;

  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_I      = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  localparam xlen_t  RESET_PC  = 32'h0;
  localparam instr_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

  typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLT, PASS_B} alu_op_e;
  typedef enum logic [1:0] {FWD_RF, FWD_EX, FWD_MEM} fwd_sel_e;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_src_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;
    logic    use_pc_a;  // operand a forced to zero (lui)
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    is_branch;
    logic    branch_ne;
    logic    is_jal;
    wb_src_e wb_src;
  } ctrl_t;

  typedef struct packed {
    xlen_t     pc4;
    xlen_t     op_a;
    xlen_t     op_b;
    xlen_t     store_data;
    reg_addr_t rd;
    ctrl_t     ctrl;
  } id_ex_t;

  typedef struct packed {
    xlen_t     pc4;
    xlen_t     alu_result;
    xlen_t     store_data;
    reg_addr_t rd;
    logic      mem_read;
    logic      mem_write;
    wb_src_e   wb_src;
  } ex_mem_t;

  typedef struct packed {
    reg_addr_t rd;
    xlen_t     wb_data;
    logic      reg_write;
  } mem_wb_t;

  typedef struct packed {
    logic  we;
    xlen_t addr;
    xlen_t wdata;
  } dmem_req_t;

endpackage
